// ==== files.f ====
+incdir+tb
hdl/mpls_ingress_pkg.sv
hdl/mpls_ingress_width_adapt.sv
hdl/mpls_ingress_port_buf.sv
hdl/mpls_ingress_sched.sv
hdl/mpls_ingress.sv
tb/mpls_ingress_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the MPLS ingress testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module mpls_ingress_tb -o mpls_ingress_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/mpls_ingress_sim 2>&1 | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
  echo "Simulation exited with an error"
  exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== tb/mpls_ingress_tb_checks.svh ====
// MPLS ingress testbench checks
// Typed compare tasks and bounded wait loops, included into the testbench top
`ifndef MPLS_INGRESS_TB_CHECKS_SVH
`define MPLS_INGRESS_TB_CHECKS_SVH

//////////////////////////////////////////////////////////////////////
// Failure exits

task automatic stop_fail();
  $display("TB FAILED");
  $fatal(1, "simulation stopped on first error");
endtask

task automatic timeout(input string what);
  $display("timed out waiting for %s", what);
  stop_fail();
endtask

//////////////////////////////////////////////////////////////////////
// Compares

// Data lanes outside keep carry stale bytes, so mask them
task automatic compare_beat(input string name, input bus_beat_t got, input bus_beat_t exp);
  logic [BUS_BYTES*8-1:0] mask;
  mask = '0;
  for (int i = 0; i < BUS_BYTES; i++) begin
    if (exp.keep[i]) begin
      mask[i*8 +: 8] = 8'hff;
    end
  end
  if (got.keep !== exp.keep || got.last !== exp.last ||
      (got.data & mask) !== (exp.data & mask)) begin
    $display("[FAIL] %s: got data %h keep %h last %h, expected data %h keep %h last %h",
             name, got.data & mask, got.keep, got.last, exp.data & mask, exp.keep, exp.last);
    stop_fail();
  end
endtask

task automatic compare_port(input string name, input logic [PORT_IDX_W-1:0] got,
                            input logic [PORT_IDX_W-1:0] exp);
  if (got !== exp) begin
    $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    stop_fail();
  end
endtask

// Only ports with a predicted drop may pulse
task automatic compare_overflow(input string name, input logic [NUM_PORTS-1:0] got,
                                input logic [NUM_PORTS-1:0] allowed);
  if ((got & ~allowed) != '0) begin
    $display("[FAIL] %s: got %h, allowed %h", name, got, allowed);
    stop_fail();
  end
endtask

//////////////////////////////////////////////////////////////////////
// Bounded waits

function automatic logic port_ready(input int p);
  if (p < N8) begin
    return p8_ready[p];
  end
  return p32_ready[p - N8];
endfunction

// Called right after driving on a falling edge
task automatic wait_in_ready(input int p);
  int t;
  t = 0;
  while (!port_ready(p)) begin
    @(negedge clk);
    t++;
    if (t > LIMIT) begin
      timeout("input ready");
    end
  end
  @(negedge clk);
endtask

task automatic wait_ovf(input int p);
  int t;
  t = 0;
  while (ovf_pending[p]) begin
    @(negedge clk);
    t++;
    if (t > LIMIT) begin
      timeout("overflow pulse");
    end
  end
endtask

task automatic wait_drained();
  int t;
  t = 0;
  while (!all_clear()) begin
    @(negedge clk);
    t++;
    if (t > LIMIT) begin
      timeout("expected packets on the converged bus");
    end
  end
endtask

// Peeks at the buffer valids inside the DUT
task automatic wait_bufs(input logic [NUM_PORTS-1:0] mask);
  int t;
  t = 0;
  while ((DUT.buf_valid & mask) != mask) begin
    @(negedge clk);
    t++;
    if (t > LIMIT) begin
      timeout("complete packets in the port buffers");
    end
  end
endtask

task automatic wait_starts(input int n);
  int t;
  t = 0;
  while (starts.size() < n) begin
    @(negedge clk);
    t++;
    if (t > LIMIT) begin
      timeout("packet starts on the converged bus");
    end
  end
endtask

`endif

// ==== tb/mpls_ingress_tb.sv ====
// MPLS ingress testbench
// LFSR traffic on all ports, packing model, drop prediction and scoreboard

module mpls_ingress_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import mpls_ingress_pkg::*;

  localparam int N8         = 2;
  localparam int N32        = 2;
  localparam int NUM_PORTS  = N8 + N32;
  localparam int BUF_DEPTH  = 16;
  localparam int CLK_PERIOD = 40;
  localparam int LIMIT      = 5000;
  // out_ready modes
  localparam int MODE_RAND  = 0;
  localparam int MODE_LOW   = 1;
  localparam int MODE_HIGH  = 2;

  logic                 clk;
  logic                 reset;
  in8_beat_t            p8_beat [N8];
  logic [N8-1:0]        p8_valid;
  logic [N8-1:0]        p8_ready;
  in32_beat_t           p32_beat [N32];
  logic [N32-1:0]       p32_valid;
  logic [N32-1:0]       p32_ready;
  ing_beat_t            out_beat;
  logic                 out_valid;
  logic                 out_ready;
  logic [NUM_PORTS-1:0] overflow;

  logic [31:0]           lfsr = 32'h7ce7_17c2;
  int                    out_mode;
  // Model state, per port
  bus_beat_t             exp_q [NUM_PORTS][$];
  logic [7:0]            pkt_bytes [NUM_PORTS][$];
  logic                  pkt_gap [NUM_PORTS][$];
  int                    wr_words [NUM_PORTS];
  int                    rd_words [NUM_PORTS];
  logic [NUM_PORTS-1:0]  ovf_pending;
  // Bus tracking
  logic                  in_pkt;
  logic [PORT_IDX_W-1:0] cur_port;
  logic [PORT_IDX_W-1:0] starts [$];
  logic [PORT_IDX_W-1:0] first;

  mpls_ingress #(
    .NUM_8B_PORTS  (N8),
    .NUM_32B_PORTS (N32),
    .BUF_DEPTH     (BUF_DEPTH)
  ) DUT (
    .clk       (clk),
    .reset     (reset),
    .p8_beat   (p8_beat),
    .p8_valid  (p8_valid),
    .p8_ready  (p8_ready),
    .p32_beat  (p32_beat),
    .p32_valid (p32_valid),
    .p32_ready (p32_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .overflow  (overflow)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  `include "mpls_ingress_tb_checks.svh"

  //////////////////////////////////////////////////////////////////////
  // Stimulus

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic all_clear();
    logic ok;
    ok = !in_pkt && (ovf_pending == '0);
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (exp_q[p].size() != 0) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  // Draw bytes and gaps, predict fit or drop, queue the packed beats
  task automatic stage_pkt(input int p, input int len);
    int        words;
    int        occ;
    int        t;
    int        lane;
    logic      fits;
    bus_beat_t b;
    words = (len + BUS_BYTES - 1) / BUS_BYTES;
    occ   = wr_words[p] - rd_words[p];
    t     = 0;
    // With the bus flowing, space only grows
    while (words <= BUF_DEPTH && occ + words > BUF_DEPTH && out_mode != MODE_LOW) begin
      @(negedge clk);
      t++;
      if (t > LIMIT) begin
        timeout("buffer space");
      end
      occ = wr_words[p] - rd_words[p];
    end
    fits = (occ + words <= BUF_DEPTH);
    pkt_bytes[p].delete();
    pkt_gap[p].delete();
    b = '0;
    for (int k = 0; k < len; k++) begin
      pkt_bytes[p].push_back(8'(rand_bits(8)));
      lane = k % BUS_BYTES;
      b.data[lane*8 +: 8] = pkt_bytes[p][k];
      b.keep[lane] = 1'b1;
      if (lane == BUS_BYTES - 1 || k == len - 1) begin
        b.last = (k == len - 1);
        if (fits) begin
          exp_q[p].push_back(b);
        end
        b = '0;
      end
    end
    for (int k = 0; k < ((p < N8) ? len : (len + 3) / 4); k++) begin
      pkt_gap[p].push_back(rand_bits(2) == 2'd0);
    end
    if (fits) begin
      wr_words[p] += words;
    end else begin
      ovf_pending[p] = 1'b1;
    end
  endtask

  task automatic put_beat(input int p, input in32_beat_t w, input logic v);
    if (p < N8) begin
      p8_beat[p].data = w.data[7:0];
      p8_beat[p].keep = w.keep[0:0];
      p8_beat[p].last = w.last;
      p8_valid[p]     = v;
    end else begin
      p32_beat[p - N8]  = w;
      p32_valid[p - N8] = v;
    end
  endtask

  // Send the staged packet of one port, lane 0 first
  task automatic drive_pkt(input int p);
    in32_beat_t w;
    int         k;
    int         nb;
    nb = (p < N8) ? 1 : 4;
    k  = 0;
    while (k < pkt_bytes[p].size()) begin
      w = '0;
      for (int i = 0; i < nb; i++) begin
        if (k + i < pkt_bytes[p].size()) begin
          w.data[i*8 +: 8] = pkt_bytes[p][k + i];
          w.keep[i] = 1'b1;
        end
      end
      k = k + nb;
      w.last = (k >= pkt_bytes[p].size());
      put_beat(p, w, 1'b1);
      wait_in_ready(p);
      if (pkt_gap[p].pop_front()) begin
        put_beat(p, '0, 1'b0);
        @(negedge clk);
      end
    end
    put_beat(p, '0, 1'b0);
    if (ovf_pending[p]) begin
      wait_ovf(p);
    end
  endtask

  always @(negedge clk) begin
    case (out_mode)
      MODE_RAND: out_ready = (rand_bits(2) != 2'd0);
      MODE_LOW:  out_ready = 1'b0;
      default:   out_ready = 1'b1;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Scoreboard, sampled late in the cycle

  task automatic take_beat(input ing_beat_t w);
    int p;
    p = int'(w.port);
    if (p >= NUM_PORTS) begin
      $display("[FAIL] out_beat.port: got %h, no such port", w.port);
      stop_fail();
    end
    // Same tag until last
    if (in_pkt) begin
      compare_port("out_beat.port", w.port, cur_port);
    end else begin
      cur_port = w.port;
      in_pkt   = 1'b1;
      starts.push_back(w.port);
    end
    if (exp_q[p].size() == 0) begin
      $display("beat arrived from port %0d with no packet expected", p);
      stop_fail();
    end
    compare_beat("out_beat.beat", w.beat, exp_q[p].pop_front());
    rd_words[p]++;
    if (w.beat.last) begin
      in_pkt = 1'b0;
    end
  endtask

  always @(negedge clk) begin
    #(CLK_PERIOD / 4);
    if (!reset) begin
      if (out_valid && out_ready) begin
        take_beat(out_beat);
      end
      if (overflow != '0) begin
        compare_overflow("overflow", overflow, ovf_pending);
        ovf_pending = ovf_pending & ~overflow;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    p8_valid    = '0;
    p32_valid   = '0;
    out_ready   = 1'b0;
    out_mode    = MODE_LOW;
    ovf_pending = '0;
    in_pkt      = 1'b0;
    cur_port    = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      put_beat(p, '0, 1'b0);
      wr_words[p] = 0;
      rd_words[p] = 0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Mixed traffic on all ports with random stalls
    out_mode = MODE_RAND;
    for (int r = 0; r < 12; r++) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        stage_pkt(p, 1 + int'(rand_bits(6)) % 40);
      end
      fork
        drive_pkt(0);
        drive_pkt(1);
        drive_pkt(2);
        drive_pkt(3);
      join
    end
    out_mode = MODE_HIGH;
    wait_drained();

    // Bus stalled, one 32-bit port fills up
    out_mode  = MODE_LOW;
    out_ready = 1'b0;
    for (int n = 0; n < 6; n++) begin
      stage_pkt(2, 24 + int'(rand_bits(4)));
      drive_pkt(2);
    end
    out_mode = MODE_HIGH;
    wait_drained();

    // Oversize packet between two normal ones
    stage_pkt(1, 12);
    drive_pkt(1);
    stage_pkt(1, 200);
    drive_pkt(1);
    stage_pkt(1, 20);
    drive_pkt(1);
    wait_drained();

    // Fairness: the port after the last grant wins, then cyclic order
    out_mode  = MODE_LOW;
    out_ready = 1'b0;
    first = PORT_IDX_W'((int'(starts[$]) + 1) % NUM_PORTS);
    stage_pkt(int'(first), 16);
    drive_pkt(int'(first));
    wait_bufs(NUM_PORTS'(1) << first);
    for (int k = 1; k < NUM_PORTS; k++) begin
      stage_pkt((int'(first) + k) % NUM_PORTS, 16);
      drive_pkt((int'(first) + k) % NUM_PORTS);
    end
    wait_bufs('1);
    out_mode = MODE_HIGH;
    wait_starts(starts.size() + NUM_PORTS);
    for (int k = 0; k < NUM_PORTS; k++) begin
      compare_port("out_beat.port", starts[starts.size() - NUM_PORTS + k],
                   PORT_IDX_W'((int'(first) + k) % NUM_PORTS));
    end
    wait_drained();

    if (all_clear()) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("expected traffic left over at end of test");
      stop_fail();
    end
  end

endmodule

// ==== hdl/mpls_ingress.sv ====
// MPLS router ingress stage
// Per-port width adapters and packet buffers merged by one scheduler

module mpls_ingress #(
  parameter int NUM_8B_PORTS  = 2,
  parameter int NUM_32B_PORTS = 2,
  parameter int BUF_DEPTH     = 16
) (
  input  logic                                    clk,
  input  logic                                    reset,
  input  mpls_ingress_pkg::in8_beat_t             p8_beat [NUM_8B_PORTS],
  input  logic [NUM_8B_PORTS-1:0]                 p8_valid,
  output logic [NUM_8B_PORTS-1:0]                 p8_ready,
  input  mpls_ingress_pkg::in32_beat_t            p32_beat [NUM_32B_PORTS],
  input  logic [NUM_32B_PORTS-1:0]                p32_valid,
  output logic [NUM_32B_PORTS-1:0]                p32_ready,
  output mpls_ingress_pkg::ing_beat_t             out_beat,
  output logic                                    out_valid,
  input  logic                                    out_ready,
  output logic [NUM_8B_PORTS+NUM_32B_PORTS-1:0]   overflow
);
  import mpls_ingress_pkg::*;

  // 8-bit ports numbered first, 32-bit ports after
  localparam int NUM_PORTS = NUM_8B_PORTS + NUM_32B_PORTS;

  bus_beat_t            ad_beat  [NUM_PORTS];
  logic [NUM_PORTS-1:0] ad_valid;
  bus_beat_t            buf_beat [NUM_PORTS];
  logic [NUM_PORTS-1:0] buf_valid;
  logic [NUM_PORTS-1:0] buf_ready;

  if (NUM_PORTS > MAX_PORTS) begin : g_bad_ports
    $error("too many ingress ports for the port tag");
  end

  //////////////////////////////////////////////////////////////////////
  // Width adapters

  for (genvar i = 0; i < NUM_8B_PORTS; i++) begin : g_p8
    mpls_ingress_width_adapt #(.in_beat_t(in8_beat_t)) u_adapt (
      .clk       (clk),
      .reset     (reset),
      .in_beat   (p8_beat[i]),
      .in_valid  (p8_valid[i]),
      .in_ready  (p8_ready[i]),
      .out_beat  (ad_beat[i]),
      .out_valid (ad_valid[i])
    );
  end

  for (genvar i = 0; i < NUM_32B_PORTS; i++) begin : g_p32
    mpls_ingress_width_adapt #(.in_beat_t(in32_beat_t)) u_adapt (
      .clk       (clk),
      .reset     (reset),
      .in_beat   (p32_beat[i]),
      .in_valid  (p32_valid[i]),
      .in_ready  (p32_ready[i]),
      .out_beat  (ad_beat[NUM_8B_PORTS + i]),
      .out_valid (ad_valid[NUM_8B_PORTS + i])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Packet buffers, one per port

  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_buf
    mpls_ingress_port_buf #(.DEPTH(BUF_DEPTH)) u_buf (
      .clk       (clk),
      .reset     (reset),
      .in_beat   (ad_beat[i]),
      .in_valid  (ad_valid[i]),
      .out_beat  (buf_beat[i]),
      .out_valid (buf_valid[i]),
      .out_ready (buf_ready[i]),
      .overflow  (overflow[i])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Converged bus

  mpls_ingress_sched #(
    .N_PORTS (NUM_PORTS),
    .beat_t  (bus_beat_t)
  ) u_sched (
    .clk       (clk),
    .reset     (reset),
    .req_beat  (buf_beat),
    .req_valid (buf_valid),
    .req_ready (buf_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

// ==== hdl/mpls_ingress_sched.sv ====
// MPLS ingress packet scheduler
// Round-robin merge of port buffers onto the converged bus, tagged by port

module mpls_ingress_sched #(
  parameter int  N_PORTS = 4,
  parameter type beat_t  = mpls_ingress_pkg::bus_beat_t
) (
  input  logic                        clk,
  input  logic                        reset,
  input  beat_t                       req_beat [N_PORTS],
  input  logic [N_PORTS-1:0]          req_valid,
  output logic [N_PORTS-1:0]          req_ready,
  output mpls_ingress_pkg::ing_beat_t out_beat,
  output logic                        out_valid,
  input  logic                        out_ready
);
  import mpls_ingress_pkg::*;

  logic [PORT_IDX_W-1:0]  rr_ptr;
  logic [PORT_IDX_W-1:0]  sel_idx;
  logic [N_PORTS-1:0]     grant;
  logic [N_PORTS-1:0]     sel_onehot;
  logic [2*N_PORTS-1:0]   req_rot;
  logic                   grant_active;
  logic                   sel_found;
  logic                   xfer_last;

  //////////////////////////////////////////////////////////////////////
  // Arbitration

  // Requests rotated so bit 0 is the pointer's port
  assign req_rot = {req_valid, req_valid} >> rr_ptr;

  // First requester at or after the pointer
  always_comb begin
    sel_found = 1'b0;
    sel_idx   = '0;
    for (int k = N_PORTS - 1; k >= 0; k--) begin
      if (req_rot[k]) begin
        sel_found = 1'b1;
        sel_idx   = PORT_IDX_W'((int'(rr_ptr) + k) % N_PORTS);
      end
    end
  end

  assign sel_onehot = N_PORTS'(1) << sel_idx;

  // Grant held for a whole packet
  always_ff @(posedge clk) begin
    if (reset) begin
      grant_active <= 1'b0;
      grant        <= '0;
      rr_ptr       <= '0;
    end else if (!grant_active) begin
      if (sel_found) begin
        grant_active <= 1'b1;
        grant        <= sel_onehot;
        // Next search starts just past the winner
        rr_ptr       <= PORT_IDX_W'((int'(sel_idx) + 1) % N_PORTS);
      end
    end else if (xfer_last) begin
      grant_active <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output mux and tag

  always_comb begin
    out_beat.beat = req_beat[0];
    out_beat.port = '0;
    for (int i = 0; i < N_PORTS; i++) begin
      if (grant[i]) begin
        out_beat.beat = req_beat[i];
        out_beat.port = PORT_IDX_W'(i);
      end
    end
  end

  assign out_valid = grant_active && |(req_valid & grant);
  // Ready goes back to the granted buffer only
  assign req_ready = grant & {N_PORTS{grant_active && out_ready}};
  assign xfer_last = out_valid && out_ready && out_beat.beat.last;

  //////////////////////////////////////////////////////////////////////
  // Checks

  // Granted buffer keeps its whole packet valid until last
  a_grant_onehot : assert property (@(posedge clk) disable iff (reset)
    grant_active |-> $onehot(grant & req_valid))
    else $error("grant not one-hot on a requesting port");

  // No interleaving of packets on the bus
  a_grant_held : assert property (@(posedge clk) disable iff (reset)
    grant_active && !xfer_last |=> grant_active && $stable(grant))
    else $error("grant changed in mid-packet");

endmodule

// ==== hdl/mpls_ingress_port_buf.sv ====
// MPLS ingress per-port packet buffer
// Store and forward, drops packets that do not fit and flags overflow

module mpls_ingress_port_buf #(
  parameter int DEPTH = 16
) (
  input  logic                        clk,
  input  logic                        reset,
  input  mpls_ingress_pkg::bus_beat_t in_beat,
  input  logic                        in_valid,
  output mpls_ingress_pkg::bus_beat_t out_beat,
  output logic                        out_valid,
  input  logic                        out_ready,
  output logic                        overflow
);
  import mpls_ingress_pkg::*;

  localparam int ADDR_W = $clog2(DEPTH);
  // Extra bit tells full from empty
  localparam int PTR_W = ADDR_W + 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  bus_beat_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] cmt_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] used;
  logic [CNT_W-1:0] pkt_cnt;
  logic             dropping;
  logic             full;
  logic             wr_en;
  logic             wr_drop;
  logic             rd_en;
  logic             pkt_in;
  logic             pkt_out;

  //////////////////////////////////////////////////////////////////////
  // Write side

  // Words held, including the packet still arriving
  assign used = wr_ptr - rd_ptr;
  // DEPTH is a power of two, so the MSB alone means full
  assign full = used[PTR_W-1];

  // First beat that does not fit
  assign wr_drop = in_valid && !dropping && full;
  assign wr_en   = in_valid && !dropping && !full;
  assign pkt_in  = wr_en && in_beat.last;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[ADDR_W-1:0]] <= in_beat;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read side

  // Only whole packets are visible
  assign out_valid = (pkt_cnt != '0);
  assign out_beat  = mem[rd_ptr[ADDR_W-1:0]];
  assign rd_en     = out_valid && out_ready;
  assign pkt_out   = rd_en && out_beat.last;

  //////////////////////////////////////////////////////////////////////
  // Pointers, packet count, drop state

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      cmt_ptr  <= '0;
      rd_ptr   <= '0;
      pkt_cnt  <= '0;
      dropping <= 1'b0;
      overflow <= 1'b0;
    end else begin
      overflow <= wr_drop;
      if (wr_drop) begin
        // Rewind to the last whole packet, then skip the rest of this one
        wr_ptr   <= cmt_ptr;
        dropping <= !in_beat.last;
      end else if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
        if (in_beat.last) begin
          cmt_ptr <= wr_ptr + 1'b1;
        end
      end else if (in_valid && dropping && in_beat.last) begin
        dropping <= 1'b0;
      end

      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      // Packet in and out in the same cycle cancel
      case ({pkt_in, pkt_out})
        2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
        2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
        default: pkt_cnt <= pkt_cnt;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks

  if ((1 << ADDR_W) != DEPTH) begin : g_bad_depth
    $error("buffer depth must be a power of two");
  end

  // Reads stay behind the committed packets
  a_rd_behind_cmt : assert property (@(posedge clk) disable iff (reset)
    PTR_W'(cmt_ptr - rd_ptr) <= PTR_W'(DEPTH))
    else $error("read pointer passed committed pointer");

endmodule

// ==== hdl/mpls_ingress_width_adapt.sv ====
// MPLS ingress width adapter
// Packs narrow port beats into converged-bus beats

module mpls_ingress_width_adapt #(
  parameter type in_beat_t = mpls_ingress_pkg::in8_beat_t
) (
  input  logic                        clk,
  input  logic                        reset,
  input  in_beat_t                    in_beat,
  input  logic                        in_valid,
  output logic                        in_ready,
  output mpls_ingress_pkg::bus_beat_t out_beat,
  output logic                        out_valid
);
  import mpls_ingress_pkg::*;

  // Input bytes per beat, from the data field
  localparam int IN_BYTES = $bits(in_beat.data) / 8;
  // Lane counter spans 0..BUS_BYTES
  localparam int LANE_W = $clog2(BUS_BYTES + 1);

  logic [LANE_W-1:0]    lane;
  logic [LANE_W-1:0]    in_cnt;
  logic [LANE_W-1:0]    next_lane;
  logic [BUS_BYTES-1:0] next_keep;
  logic                 accept;
  logic                 fill;

  // Output register doubles as accumulator, so hold off input while it drains
  assign in_ready = !out_valid;
  assign accept   = in_valid && in_ready;

  // Valid bytes in this input beat
  always_comb begin
    in_cnt = '0;
    for (int i = 0; i < IN_BYTES; i++) begin
      if (in_beat.keep[i]) begin
        in_cnt = in_cnt + 1'b1;
      end
    end
  end

  assign next_lane = lane + in_cnt;
  // Eighth byte filled or end of packet
  assign fill = accept && ((next_lane == LANE_W'(BUS_BYTES)) || in_beat.last);

  // Contiguous keep up to the new fill level
  always_comb begin
    next_keep = '0;
    for (int i = 0; i < BUS_BYTES; i++) begin
      if (i < int'(next_lane)) begin
        next_keep[i] = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Lane tracking and output valid

  always_ff @(posedge clk) begin
    if (reset) begin
      lane      <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= fill;
      if (fill) begin
        lane <= '0;
      end else if (accept) begin
        lane <= next_lane;
      end
    end
  end

  // Byte shift-in at the current lane
  always_ff @(posedge clk) begin
    if (accept) begin
      for (int i = 0; i < IN_BYTES; i++) begin
        if (in_beat.keep[i]) begin
          out_beat.data[(int'(lane) + i)*8 +: 8] <= in_beat.data[i*8 +: 8];
        end
      end
      out_beat.keep <= next_keep;
      out_beat.last <= in_beat.last;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks

  // Port width must tile the converged bus
  if (BUS_BYTES % IN_BYTES != 0) begin : g_bad_width
    $error("input width does not divide the converged bus");
  end

  // Upstream sends partial beats only at end of packet
  a_full_keep : assert property (@(posedge clk) disable iff (reset)
    in_valid && !in_beat.last |-> &in_beat.keep)
    else $error("non-last input beat with partial keep");

endmodule

// ==== hdl/mpls_ingress_pkg.sv ====
// MPLS ingress shared definitions
// Converged bus sizing, port beat structs and port tag width

package mpls_ingress_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes

  // Bytes per converged-bus beat
  localparam int BUS_BYTES = 8;
  // Upper bound on physical ports, all widths together
  localparam int MAX_PORTS = 8;
  // Port tag carried with each converged beat
  localparam int PORT_IDX_W = 3;

  //////////////////////////////////////////////////////////////////////
  // Beat types

  // Converged bus beat, keep contiguous from lane 0
  typedef struct packed {
    logic [BUS_BYTES*8-1:0] data;
    logic [BUS_BYTES-1:0]   keep;
    logic                   last;
  } bus_beat_t;

  // 8-bit physical port
  typedef struct packed {
    logic [7:0] data;
    logic [0:0] keep;
    logic       last;
  } in8_beat_t;

  // 32-bit physical port, partial keep only on last
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  keep;
    logic        last;
  } in32_beat_t;

  // Converged-bus word, beat plus source port
  typedef struct packed {
    bus_beat_t             beat;
    logic [PORT_IDX_W-1:0] port;
  } ing_beat_t;

endpackage
